/* stream_fabric.f */
// Package first, then the RTL from leaf to top, then the testbench.
source/stream_pkg.sv
source/stream_stage.sv
source/stream_split.sv
source/stream_merge.sv
source/stream_fabric.sv
dv/stream_fabric_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the stream fabric testbench with Verilator and runs it.
# The run fails when the log holds the fail line or no result line at all.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f stream_fabric.f \
    --top-module stream_fabric_tb \
    -o stream_fabric_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed."; exit 1; }

./obj_dir/stream_fabric_sim 2>&1 | tee "$LOG"

grep -q "Simulation finished: FAIL" "$LOG" && { echo "Run failed."; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "Run gave no result."; exit 1; }
echo "Run passed."

/* dv/stream_fabric_tb.sv */
/*
 Testbench of the four-port stream crossbar. A table of beats is fed
 per source, outputs are checked against per-flow scoreboards.
*/
`timescale 1ns/1ps

module stream_fabric_tb;

    import stream_pkg::*;

    localparam int CLK_HALF   = 2;
    localparam int ROWS       = 265;  // All table rows of tests 2 to 6.
    localparam int BURST      = 8;    // Beats per source in the contention test.
    localparam int MIXED_ROWS = 200;
    localparam int STREAM_LEN = 16;

    typedef struct packed {
        port_id_t   src;
        port_id_t   dst;
        payload_t   payload;
        logic [3:0] gap;      // Idle cycles before the beat is offered.
    } row_t;

    logic             clk = 1'b0;
    logic             reset;
    logic [PORTS-1:0] in_valid;
    stream_beat_t     in_beat [PORTS];
    logic [PORTS-1:0] in_ready;
    logic [PORTS-1:0] out_valid;
    stream_beat_t     out_beat [PORTS];
    logic [PORTS-1:0] out_ready;

    row_t             table_rows [ROWS];
    int               first_row [7];
    int               row_count [7];
    int               n_rows;
    payload_t         exp_q [PORTS*PORTS][$];  // Indexed source * PORTS + destination.
    logic [31:0]      lfsr_state;
    int               cycle = 0;
    int               sent = 0;
    int               received = 0;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               test_id = 0;
    int               in_cycle [PORTS];
    int               last_cycle [PORTS];
    port_id_t         last_src [PORTS];
    logic [PORTS-1:0] seen;
    logic             bp_on;

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    stream_fabric dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        fb;

        value = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic add_row(input int src, input int dst, input logic [31:0] payload,
                           input int gap);
        table_rows[n_rows] = '{src: port_id_t'(src), dst: port_id_t'(dst),
                               payload: payload, gap: 4'(gap)};
        n_rows++;
    endtask

    task automatic build_table();
        int src;
        int dst;
        int gap;

        n_rows       = 0;
        first_row[2] = n_rows;
        add_row(1, 2, 32'hA5A5_0102, 0);
        row_count[2] = n_rows - first_row[2];

        first_row[3] = n_rows;  // Every pair once, source by source.
        for (int s = 0; s < PORTS; s++) begin
            for (int d = 0; d < PORTS; d++) begin
                add_row(s, d, 32'h3000_0000 + s * 16 + d, 3);
            end
        end
        row_count[3] = n_rows - first_row[3];

        first_row[4] = n_rows;
        for (int k = 0; k < BURST; k++) begin
            for (int s = 0; s < PORTS; s++) begin
                add_row(s, 0, 32'h4000_0000 + s * 256 + k, 0);
            end
        end
        row_count[4] = n_rows - first_row[4];

        first_row[5] = n_rows;
        for (int k = 0; k < MIXED_ROWS; k++) begin
            src = int'(lfsr_bits(2));
            dst = int'(lfsr_bits(2));
            gap = int'(lfsr_bits(2));
            add_row(src, dst, lfsr_bits(32), gap);
        end
        row_count[5] = n_rows - first_row[5];

        first_row[6] = n_rows;
        for (int k = 0; k < STREAM_LEN; k++) begin
            add_row(3, 1, 32'h6000_0000 + k, 0);
        end
        row_count[6] = n_rows - first_row[6];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Walks the rows of one source. Called a little after a rising edge.
    task automatic drive_source(input int src, input int first, input int count);
        row_t row;
        int   idx;

        for (int r = first; r < first + count; r++) begin
            row = table_rows[r];
            if (int'(row.src) == src) begin
                if (row.gap != 4'd0) begin
                    in_valid[src] = 1'b0;
                    repeat (int'(row.gap)) begin
                        @(posedge clk);
                        #0.5;
                    end
                end
                in_valid[src] = 1'b1;
                in_beat[src]  = '{payload: row.payload, id: row.dst};
                @(negedge clk);
                while (!in_ready[src]) begin
                    @(negedge clk);  // The beat stays put until taken.
                end
                idx = src * PORTS + int'(row.dst);
                exp_q[idx].push_back(row.payload);
                in_cycle[src] = cycle;
                sent++;
                @(posedge clk);
                #0.5;
            end
        end
        in_valid[src] = 1'b0;
    endtask

    task automatic run_rows(input int first, input int count);
        @(posedge clk);
        #0.5;
        fork
            drive_source(0, first, count);
            drive_source(1, first, count);
            drive_source(2, first, count);
            drive_source(3, first, count);
        join
        wait (received == sent);  // Every beat sent has come out.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_output(input int p);
        stream_beat_t beat;
        int           src;
        int           idx;
        payload_t     expected;
        port_id_t     next_src;

        beat     = out_beat[p];
        src      = int'(beat.id);
        idx      = src * PORTS + p;
        next_src = last_src[p] + port_id_t'(1);
        received++;
        if (exp_q[idx].size() == 0) begin
            $display("Output %0d got a beat from source %0d that no one sent there", p, src);
            errors++;
        end else begin
            expected = exp_q[idx].pop_front();
            if (beat.payload !== expected) begin
                $display("Mismatch out_beat[%0d].payload: expected %h, got %h",
                         p, expected, beat.payload);
                errors++;
            end
        end
        if (test_id == 2) begin
            if (beat.id !== port_id_t'(1)) begin
                $display("Mismatch out_beat[%0d].id: expected 1, got %h", p, beat.id);
                errors++;
            end
            if (cycle - in_cycle[1] != 2) begin
                $display("Lone beat took %0d cycles instead of 2", cycle - in_cycle[1]);
                errors++;
            end
        end
        if (test_id == 4 && seen[p] && beat.id !== next_src) begin
            $display("Mismatch out_beat[%0d].id: expected %h, got %h", p, next_src, beat.id);
            errors++;
        end
        if (test_id == 6 && seen[p] && cycle != last_cycle[p] + 1) begin
            $display("Output %0d left a bubble of %0d cycles", p, cycle - last_cycle[p] - 1);
            errors++;
        end
        seen[p]       = 1'b1;
        last_src[p]   = beat.id;
        last_cycle[p] = cycle;
    endtask

    // Sampled on the falling edge, where valid and ready have settled.
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    check_output(p);
                end
            end
        end
    end

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d, %s: ok", test_id, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: failed with %0d errors", test_id, name,
                     errors - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        int errors_before;

        reset      = 1'b1;
        in_valid   = '0;
        out_ready  = '1;
        bp_on      = 1'b0;
        seen       = '0;
        lfsr_state = 32'h7979;
        for (int p = 0; p < PORTS; p++) begin
            in_beat[p]    = '0;
            in_cycle[p]   = 0;
            last_cycle[p] = 0;
            last_src[p]   = '0;
        end
        build_table();

        test_id       = 1;
        errors_before = errors;
        repeat (9) begin
            @(posedge clk);
            @(negedge clk);
            if (out_valid !== '0) begin
                $display("Mismatch out_valid: expected 0, got %h", out_valid);
                errors++;
            end
        end
        @(posedge clk);
        #0.5;
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (out_valid !== '0) begin
                $display("Mismatch out_valid: expected 0, got %h", out_valid);
                errors++;
            end
        end
        finish_test("reset", errors_before);

        test_id       = 2;
        errors_before = errors;
        seen          = '0;
        run_rows(first_row[2], row_count[2]);
        finish_test("single-beat latency", errors_before);

        test_id       = 3;
        errors_before = errors;
        seen          = '0;
        run_rows(first_row[3], row_count[3]);
        finish_test("full routing", errors_before);

        test_id       = 4;
        errors_before = errors;
        seen          = '0;
        run_rows(first_row[4], row_count[4]);
        finish_test("contention fairness", errors_before);

        test_id       = 5;
        errors_before = errors;
        seen          = '0;
        bp_on         = 1'b1;
        fork
            begin
                run_rows(first_row[5], row_count[5]);
                bp_on = 1'b0;
            end
            begin
                while (bp_on) begin
                    @(posedge clk);
                    #0.5;
                    for (int p = 0; p < PORTS; p++) begin
                        out_ready[p] = (lfsr_bits(2) != 0);  // Ready three times in four.
                    end
                end
            end
        join
        out_ready = '1;
        finish_test("back-pressure", errors_before);

        test_id       = 6;
        errors_before = errors;
        seen          = '0;
        run_rows(first_row[6], row_count[6]);
        finish_test("throughput", errors_before);

        for (int i = 0; i < PORTS * PORTS; i++) begin
            if (exp_q[i].size() != 0) begin
                $display("%0d beats from source %0d to output %0d never arrived",
                         exp_q[i].size(), i / PORTS, i % PORTS);
                errors++;
            end
        end

        $display("Tests run %0d, failed %0d, errors %0d, beats sent %0d, received %0d",
                 tests_run, tests_failed, errors, sent, received);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Forty cycles per table beat leaves room for heavy back-pressure.
    initial begin : watchdog
        repeat (ROWS * 40 + 1000) @(posedge clk);
        $display("Watchdog expired in test %0d with %0d of %0d beats received",
                 test_id, received, sent);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* source/stream_fabric.sv */
/*
 Four-port stream crossbar. Each input split fans out one lane per
 output, and each output merge collects the lanes aimed at it.
*/
`timescale 1ns/1ps

module stream_fabric (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [stream_pkg::PORTS-1:0] in_valid,
    input  stream_pkg::stream_beat_t in_beat [stream_pkg::PORTS],
    output logic [stream_pkg::PORTS-1:0] in_ready,
    output logic [stream_pkg::PORTS-1:0] out_valid,
    output stream_pkg::stream_beat_t out_beat [stream_pkg::PORTS],
    input  logic [stream_pkg::PORTS-1:0] out_ready
);

    import stream_pkg::*;

    // Lanes as seen from the split side, indexed [source][destination].
    logic [PORTS-1:0] split_valid [PORTS];
    logic [PORTS-1:0] split_ready [PORTS];
    stream_beat_t     split_beat  [PORTS][PORTS];

    // The same lanes as seen from the merge side, indexed [destination][source].
    logic [PORTS-1:0] merge_valid [PORTS];
    logic [PORTS-1:0] merge_ready [PORTS];
    stream_beat_t     merge_beat  [PORTS][PORTS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Crossing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar s = 0; s < PORTS; s++) begin : g_src
        for (genvar d = 0; d < PORTS; d++) begin : g_dst
            assign merge_valid[d][s] = split_valid[s][d];
            assign merge_beat[d][s]  = split_beat[s][d];
            assign split_ready[s][d] = merge_ready[d][s];  // Ready flows back.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Splits and merges
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar p = 0; p < PORTS; p++) begin : g_port
        stream_split split_inst (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (in_valid[p]),
            .in_beat    (in_beat[p]),
            .in_ready   (in_ready[p]),
            .lane_valid (split_valid[p]),
            .lane_beat  (split_beat[p]),
            .lane_ready (split_ready[p])
        );

        stream_merge merge_inst (
            .clk        (clk),
            .reset      (reset),
            .lane_valid (merge_valid[p]),
            .lane_beat  (merge_beat[p]),
            .lane_ready (merge_ready[p]),
            .out_valid  (out_valid[p]),
            .out_beat   (out_beat[p]),
            .out_ready  (out_ready[p])
        );
    end

endmodule

/* source/stream_merge.sv */
/*
 Stream merge. A round-robin arbiter picks one of the lanes aimed at
 this output, and the chosen beat leaves through a registered stage
 with its id set to the lane number, which is the source port.
*/
`timescale 1ns/1ps

module stream_merge (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [stream_pkg::PORTS-1:0] lane_valid,
    input  stream_pkg::stream_beat_t lane_beat [stream_pkg::PORTS],
    output logic [stream_pkg::PORTS-1:0] lane_ready,
    output logic                     out_valid,
    output stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready
);

    import stream_pkg::*;

    port_id_t     ptr_q;        // First lane looked at in the search.
    port_id_t     grant_idx;
    logic         grant_found;
    logic         stage_ready;
    logic         transfer;
    stream_beat_t stage_beat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Walk the lanes starting at the pointer and take the first valid one.
    always_comb begin
        port_id_t cand;

        grant_found = 1'b0;
        grant_idx   = ptr_q;
        for (int k = 0; k < PORTS; k++) begin
            cand = ptr_q + port_id_t'(k);  // Wraps around the port count.
            if (!grant_found && lane_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    assign transfer = grant_found && stage_ready;

    // Only the granted lane is told to move.
    always_comb begin
        for (int k = 0; k < PORTS; k++) begin
            lane_ready[k] = transfer && (grant_idx == port_id_t'(k));
        end
    end

    // The pointer moves past the winner once its beat is taken.
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (transfer) begin
            ptr_q <= grant_idx + port_id_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        stage_beat.payload = lane_beat[grant_idx].payload;
        stage_beat.id      = grant_idx;  // Tag with the source port.
    end

    stream_stage #(
        .PIPELINE_MODE(STREAM_PIPELINE_MODE_REGISTERED)
    ) out_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (grant_found),
        .in_beat   (stage_beat),
        .in_ready  (stage_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // At most one lane moves per cycle, and only a lane that offers a beat.
    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(lane_ready) && ((lane_ready & ~lane_valid) == '0));

endmodule

/* source/stream_split.sv */
/*
 Stream split. Steers each beat of one input stream to the lane named
 by its destination id. Every lane has its own registered stage.
*/
`timescale 1ns/1ps

module stream_split (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  stream_pkg::stream_beat_t in_beat,
    output logic                     in_ready,
    output logic [stream_pkg::PORTS-1:0] lane_valid,
    output stream_pkg::stream_beat_t lane_beat [stream_pkg::PORTS],
    input  logic [stream_pkg::PORTS-1:0] lane_ready
);

    import stream_pkg::*;

    logic [PORTS-1:0] produce;         // One-hot decode of the destination.
    logic [PORTS-1:0] stage_in_valid;
    logic [PORTS-1:0] stage_in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        produce = '0;
        produce[in_beat.id] = 1'b1;
    end

    // Only the addressed lane sees the valid bit.
    assign stage_in_valid = in_valid ? produce : '0;

    // The input moves when the addressed stage has room.
    assign in_ready = stage_in_ready[in_beat.id];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 0; k < PORTS; k++) begin : g_lane
        stream_stage #(
            .PIPELINE_MODE(STREAM_PIPELINE_MODE_REGISTERED)
        ) lane_stage (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (stage_in_valid[k]),
            .in_beat   (in_beat),          // The beat goes out unchanged.
            .in_ready  (stage_in_ready[k]),
            .out_valid (lane_valid[k]),
            .out_beat  (lane_beat[k]),
            .out_ready (lane_ready[k])
        );
    end

    // A beat is offered to a single lane only, so it can never be duplicated.
    a_one_lane: assert property (@(posedge clk) disable iff (reset)
        $onehot0(stage_in_valid));

    // A held input keeps its lane valid until that lane takes it.
    a_in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_beat));

endmodule

/* source/stream_stage.sv */
/*
 Stream pipeline stage. In registered mode it holds up to two beats,
 a main entry and a skid entry, so that it runs at full rate while its
 ready output comes straight from a flop. Bypass mode is plain wires.
*/
`timescale 1ns/1ps

module stream_stage #(
    parameter stream_pkg::stream_pipeline_mode_t PIPELINE_MODE =
        stream_pkg::STREAM_PIPELINE_MODE_REGISTERED
)(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  stream_pkg::stream_beat_t in_beat,
    output logic                     in_ready,
    output logic                     out_valid,
    output stream_pkg::stream_beat_t out_beat,
    input  logic                     out_ready
);

    import stream_pkg::*;

    if (PIPELINE_MODE == STREAM_PIPELINE_MODE_BYPASS) begin : g_bypass
        assign out_valid = in_valid;
        assign out_beat  = in_beat;
        assign in_ready  = out_ready;
    end else begin : g_registered
        stage_state_t state_q;
        stage_state_t state_d;
        stream_beat_t main_q;  // Beat shown at the output.
        stream_beat_t skid_q;  // Beat caught while the output stalled.
        logic         ready_q;
        logic         push;
        logic         pop;

        assign push = in_valid && ready_q;
        assign pop  = (state_q != STAGE_EMPTY) && out_ready;

        always_comb begin
            state_d = state_q;
            case (state_q)
                STAGE_EMPTY: if (push) state_d = STAGE_ONE;
                STAGE_ONE: begin
                    if (push && !pop) begin
                        state_d = STAGE_TWO;   // Output stalled, park the new beat.
                    end else if (!push && pop) begin
                        state_d = STAGE_EMPTY;
                    end
                end
                STAGE_TWO: if (pop) state_d = STAGE_ONE;
                default: state_d = STAGE_EMPTY;
            endcase
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                state_q <= STAGE_EMPTY;
                ready_q <= 1'b0;  // Nothing is taken while reset is high.
            end else begin
                state_q <= state_d;
                ready_q <= (state_d != STAGE_TWO);
            end
        end

        // Data path. The skid entry refills the main entry once the output moves.
        always_ff @(posedge clk) begin
            case (state_q)
                STAGE_EMPTY: if (push) main_q <= in_beat;
                STAGE_ONE: begin
                    if (push && pop) begin
                        main_q <= in_beat;
                    end else if (push) begin
                        skid_q <= in_beat;
                    end
                end
                STAGE_TWO: if (pop) main_q <= skid_q;
                default: ;
            endcase
        end

        assign in_ready  = ready_q;
        assign out_valid = (state_q != STAGE_EMPTY);
        assign out_beat  = main_q;

        // A stalled beat must not change under the consumer.
        a_out_stable: assert property (@(posedge clk) disable iff (reset)
            out_valid && !out_ready |=> out_valid && $stable(out_beat));
    end

endmodule

/* source/stream_pkg.sv */
/*
 Stream fabric package. Holds the port count, the beat format shared
 by every valid/ready stream, and the enums of the pipeline stages.
*/
package stream_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PORTS         = 4;  // Input ports and output ports alike.
    localparam int PAYLOAD_WIDTH = 32;
    localparam int ID_WIDTH      = $clog2(PORTS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A port number. On fabric inputs it names the destination,
    // on fabric outputs it names the source.
    typedef logic [ID_WIDTH-1:0]      port_id_t;
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // One beat as it travels on any stream of the fabric.
    typedef struct packed {
        payload_t payload;
        port_id_t id;
    } stream_beat_t;

    // Behavior of a stream_stage.
    typedef enum logic {
        STREAM_PIPELINE_MODE_REGISTERED,  // One cycle of latency, registered ready.
        STREAM_PIPELINE_MODE_BYPASS       // Plain wires.
    } stream_pipeline_mode_t;

    // Occupancy of the skid-buffered stage.
    typedef enum logic [1:0] {
        STAGE_EMPTY,
        STAGE_ONE,   // Main register holds a beat.
        STAGE_TWO    // Main and skid registers both hold a beat.
    } stage_state_t;

endpackage
